/* Bender.yml */
package:
  name: riscv_id_stage

sources:
  - files:
      - riscv_id_pkg.sv
      - inst_decoder.sv
      - operand_forward.sv
      - branch_resolve.sv
      - id_ex_reg.sv
      - id_stage.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_id_stage.sv

/* branch_resolve.sv */
`timescale 1ns/1ps

module branch_resolve import riscv_id_pkg::*; (
	input  dec_ctrl_t  ctrl_i,
	input  inst_t      inst_i,
	input  xlen_t      pc_i,
	input  xlen_t      op1_i,
	input  xlen_t      op2_i,
	input  logic       pred_taken_i,
	output redirect_t  redirect_o,
	output br_status_t status_o
);

	xlen_t b_imm;
	xlen_t j_imm;
	logic  is_cond;
	logic  is_jump;
	logic  cond;

	assign b_imm = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
	assign j_imm = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

	always_comb begin
		is_cond = 1'b1;
		cond    = 1'b0;
		case (ctrl_i.br_kind)
			BR_EQ:   cond = (op1_i == op2_i);
			BR_NE:   cond = (op1_i != op2_i);
			BR_LT:   cond = ($signed(op1_i) < $signed(op2_i));
			BR_GE:   cond = ($signed(op1_i) >= $signed(op2_i));
			BR_LTU:  cond = (op1_i < op2_i);
			BR_GEU:  cond = (op1_i >= op2_i);
			default: is_cond = 1'b0; // none, jal, jalr
		endcase
	end

	assign is_jump = (ctrl_i.br_kind == BR_JAL);

	always_comb begin
		redirect_o = '0;
		if (is_jump && ctrl_i.rs1_read) begin // jalr
			redirect_o.flag   = 1'b1;
			redirect_o.target = op1_i + ctrl_i.imm;
		end else if (is_jump) begin
			redirect_o.flag   = 1'b1;
			redirect_o.target = pc_i + j_imm;
		end else if (is_cond && cond && !pred_taken_i) begin
			redirect_o.flag   = 1'b1;
			redirect_o.target = pc_i + b_imm;
		end
	end

	assign status_o.is_branch = is_cond;
	assign status_o.taken     = is_cond && cond;
	assign status_o.pred_true = is_cond && cond && pred_taken_i;

endmodule

/* id_ex_reg.sv */
`timescale 1ns/1ps

module id_ex_reg import riscv_id_pkg::*; (
	input  logic      clk,
	input  logic      arst_n_i,
	input  logic      stall_i,
	input  dec_ctrl_t ctrl_i,
	input  xlen_t     op1_i,
	input  xlen_t     op2_i,
	output id_ex_t    id_ex_o
);

	id_ex_t id_ex_d;

	always_comb begin
		id_ex_d.aluop     = ctrl_i.aluop;
		id_ex_d.alusel    = ctrl_i.alusel;
		id_ex_d.wreg      = ctrl_i.wreg;
		id_ex_d.wd        = ctrl_i.wd;
		id_ex_d.op1       = op1_i;
		id_ex_d.op2       = op2_i;
		id_ex_d.link_addr = ctrl_i.link_addr;
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			id_ex_o <= ID_EX_BUBBLE;
		end else if (stall_i) begin
			id_ex_o <= ID_EX_BUBBLE; // fetch replays the instruction
		end else begin
			id_ex_o <= id_ex_d;
		end
	end

endmodule

/* id_stage.sv */
`timescale 1ns/1ps

module id_stage import riscv_id_pkg::*; (
	input  logic       clk,
	input  logic       arst_n_i,
	input  inst_t      inst_i,
	input  xlen_t      pc_i,
	input  logic       pred_taken_i,
	input  fwd_src_t   ex_fwd_i,
	input  fwd_src_t   mem_fwd_i,
	input  xlen_t      rs1_data_i,
	input  xlen_t      rs2_data_i,
	output reg_addr_t  rs1_addr_o,
	output reg_addr_t  rs2_addr_o,
	output id_ex_t     id_ex_o,
	output redirect_t  redirect_o,
	output br_status_t br_status_o,
	output logic       stall_o
);

	dec_ctrl_t ctrl;
	xlen_t     op1;
	xlen_t     op2;
	logic      hazard1;
	logic      hazard2;

	assign rs1_addr_o = ctrl.rs1;
	assign rs2_addr_o = ctrl.rs2;
	assign stall_o    = hazard1 | hazard2;

	inst_decoder u_dec (
		.inst_i (inst_i),
		.pc_i   (pc_i),
		.ctrl_o (ctrl)
	);

	operand_forward u_op1 (
		.read_i        (ctrl.rs1_read),
		.addr_i        (ctrl.rs1),
		.rf_data_i     (rs1_data_i),
		.imm_i         (ctrl.imm),
		.ex_fwd_i      (ex_fwd_i),
		.mem_fwd_i     (mem_fwd_i),
		.op_o          (op1),
		.load_hazard_o (hazard1)
	);

	operand_forward u_op2 (
		.read_i        (ctrl.rs2_read),
		.addr_i        (ctrl.rs2),
		.rf_data_i     (rs2_data_i),
		.imm_i         (ctrl.imm),
		.ex_fwd_i      (ex_fwd_i),
		.mem_fwd_i     (mem_fwd_i),
		.op_o          (op2),
		.load_hazard_o (hazard2)
	);

	branch_resolve u_br (
		.ctrl_i       (ctrl),
		.inst_i       (inst_i),
		.pc_i         (pc_i),
		.op1_i        (op1),
		.op2_i        (op2),
		.pred_taken_i (pred_taken_i),
		.redirect_o   (redirect_o),
		.status_o     (br_status_o)
	);

	id_ex_reg u_id_ex (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.stall_i  (stall_o),
		.ctrl_i   (ctrl),
		.op1_i    (op1),
		.op2_i    (op2),
		.id_ex_o  (id_ex_o)
	);

endmodule

/* inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder import riscv_id_pkg::*; (
	input  inst_t     inst_i,
	input  xlen_t     pc_i,
	output dec_ctrl_t ctrl_o
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic       alt;
	logic       f7_ok;
	logic       valid;
	xlen_t      i_imm;
	xlen_t      u_imm;
	xlen_t      shamt;
	xlen_t      pc_plus_4;

	assign opcode    = inst_i[6:0];
	assign funct3    = inst_i[14:12];
	assign funct7    = inst_i[31:25];
	assign alt       = (funct7 == FUNCT7_ALT);
	assign i_imm     = {{20{inst_i[31]}}, inst_i[31:20]};
	assign u_imm     = {inst_i[31:12], 12'b0};
	assign shamt     = {27'b0, inst_i[24:20]};
	assign pc_plus_4 = pc_i + 32'd4;

	// funct7 is zero except for the alternate add/shift-right forms
	assign f7_ok = (funct7 == FUNCT7_BASE) ||
		(alt && (funct3 == FUNCT3_ADD || funct3 == FUNCT3_SRL));

	always_comb begin
		ctrl_o = DEC_BUBBLE;
		valid  = 1'b1;
		case (opcode)
			OPC_OP_IMM: begin
				ctrl_o.wreg     = 1'b1;
				ctrl_o.rs1_read = 1'b1;
				ctrl_o.imm      = i_imm;
				case (funct3)
					FUNCT3_ADD:  {ctrl_o.aluop, ctrl_o.alusel} = {ALU_ADD, SEL_ARITH};
					FUNCT3_SLT:  {ctrl_o.aluop, ctrl_o.alusel} = {ALU_SLT, SEL_ARITH};
					FUNCT3_SLTU: {ctrl_o.aluop, ctrl_o.alusel} = {ALU_SLTU, SEL_ARITH};
					FUNCT3_XOR:  {ctrl_o.aluop, ctrl_o.alusel} = {ALU_XOR, SEL_LOGIC};
					FUNCT3_OR:   {ctrl_o.aluop, ctrl_o.alusel} = {ALU_OR, SEL_LOGIC};
					FUNCT3_AND:  {ctrl_o.aluop, ctrl_o.alusel} = {ALU_AND, SEL_LOGIC};
					FUNCT3_SLL: begin
						{ctrl_o.aluop, ctrl_o.alusel} = {ALU_SLL, SEL_SHIFT};
						ctrl_o.imm = shamt;
						valid = (funct7 == FUNCT7_BASE);
					end
					default: begin // srli / srai
						{ctrl_o.aluop, ctrl_o.alusel} = {alt ? ALU_SRA : ALU_SRL, SEL_SHIFT};
						ctrl_o.imm = shamt;
						valid = f7_ok;
					end
				endcase
			end
			OPC_OP: begin
				ctrl_o.wreg     = 1'b1;
				ctrl_o.rs1_read = 1'b1;
				ctrl_o.rs2_read = 1'b1;
				valid = f7_ok;
				case (funct3)
					FUNCT3_ADD:  {ctrl_o.aluop, ctrl_o.alusel} = {alt ? ALU_SUB : ALU_ADD, SEL_ARITH};
					FUNCT3_SLT:  {ctrl_o.aluop, ctrl_o.alusel} = {ALU_SLT, SEL_ARITH};
					FUNCT3_SLTU: {ctrl_o.aluop, ctrl_o.alusel} = {ALU_SLTU, SEL_ARITH};
					FUNCT3_XOR:  {ctrl_o.aluop, ctrl_o.alusel} = {ALU_XOR, SEL_LOGIC};
					FUNCT3_OR:   {ctrl_o.aluop, ctrl_o.alusel} = {ALU_OR, SEL_LOGIC};
					FUNCT3_AND:  {ctrl_o.aluop, ctrl_o.alusel} = {ALU_AND, SEL_LOGIC};
					FUNCT3_SLL:  {ctrl_o.aluop, ctrl_o.alusel} = {ALU_SLL, SEL_SHIFT};
					default:     {ctrl_o.aluop, ctrl_o.alusel} = {alt ? ALU_SRA : ALU_SRL, SEL_SHIFT};
				endcase
			end
			OPC_LUI: begin
				{ctrl_o.aluop, ctrl_o.alusel} = {ALU_SLL, SEL_JUMP_BRANCH};
				ctrl_o.wreg      = 1'b1;
				ctrl_o.link_addr = u_imm;
			end
			OPC_AUIPC: begin
				{ctrl_o.aluop, ctrl_o.alusel} = {ALU_ADD, SEL_JUMP_BRANCH};
				ctrl_o.wreg      = 1'b1;
				ctrl_o.link_addr = pc_i + u_imm;
			end
			OPC_JAL: begin
				{ctrl_o.aluop, ctrl_o.alusel} = {ALU_JAL, SEL_JUMP_BRANCH};
				ctrl_o.wreg      = 1'b1;
				ctrl_o.link_addr = pc_plus_4;
				ctrl_o.br_kind   = BR_JAL;
			end
			OPC_JALR: begin
				{ctrl_o.aluop, ctrl_o.alusel} = {ALU_JALR, SEL_JUMP_BRANCH};
				ctrl_o.wreg      = 1'b1;
				ctrl_o.rs1_read  = 1'b1;
				ctrl_o.imm       = i_imm;
				ctrl_o.link_addr = pc_plus_4;
				ctrl_o.br_kind   = BR_JALR;
				valid = (funct3 == FUNCT3_JALR);
			end
			OPC_BRANCH: begin
				{ctrl_o.aluop, ctrl_o.alusel} = {ALU_BRANCH, SEL_JUMP_BRANCH};
				ctrl_o.rs1_read = 1'b1;
				ctrl_o.rs2_read = 1'b1;
				case (funct3)
					FUNCT3_BEQ:  ctrl_o.br_kind = BR_EQ;
					FUNCT3_BNE:  ctrl_o.br_kind = BR_NE;
					FUNCT3_BLT:  ctrl_o.br_kind = BR_LT;
					FUNCT3_BGE:  ctrl_o.br_kind = BR_GE;
					FUNCT3_BLTU: ctrl_o.br_kind = BR_LTU;
					FUNCT3_BGEU: ctrl_o.br_kind = BR_GEU;
					default:     valid = 1'b0;
				endcase
			end
			OPC_LOAD: begin
				ctrl_o.alusel   = SEL_LOAD_STORE;
				ctrl_o.wreg     = 1'b1;
				ctrl_o.rs1_read = 1'b1;
				ctrl_o.imm      = i_imm; // address offset rides on op2
				case (funct3)
					FUNCT3_LB:  ctrl_o.aluop = ALU_LB;
					FUNCT3_LH:  ctrl_o.aluop = ALU_LH;
					FUNCT3_LW:  ctrl_o.aluop = ALU_LW;
					FUNCT3_LBU: ctrl_o.aluop = ALU_LBU;
					FUNCT3_LHU: ctrl_o.aluop = ALU_LHU;
					default:    valid = 1'b0;
				endcase
			end
			OPC_STORE: begin
				ctrl_o.alusel   = SEL_LOAD_STORE;
				ctrl_o.rs1_read = 1'b1;
				ctrl_o.rs2_read = 1'b1;
				case (funct3)
					FUNCT3_SB: ctrl_o.aluop = ALU_SB;
					FUNCT3_SH: ctrl_o.aluop = ALU_SH;
					FUNCT3_SW: ctrl_o.aluop = ALU_SW;
					default:   valid = 1'b0;
				endcase
			end
			default: valid = 1'b0;
		endcase

		if (!valid)
			ctrl_o = DEC_BUBBLE;

		// source fields go to the regfile whatever the format
		ctrl_o.rs1 = inst_i[19:15];
		ctrl_o.rs2 = inst_i[24:20];
		ctrl_o.wd  = ctrl_o.wreg ? inst_i[11:7] : 5'd0;
	end

endmodule

/* operand_forward.sv */
`timescale 1ns/1ps

module operand_forward import riscv_id_pkg::*; (
	input  logic      read_i,
	input  reg_addr_t addr_i,
	input  xlen_t     rf_data_i,
	input  xlen_t     imm_i,
	input  fwd_src_t  ex_fwd_i,
	input  fwd_src_t  mem_fwd_i,
	output xlen_t     op_o,
	output logic      load_hazard_o
);

	logic ex_is_load;
	logic ex_hit;
	logic mem_hit;

	// load result is not ready until the memory stage
	always_comb begin
		case (ex_fwd_i.aluop)
			ALU_LB, ALU_LH, ALU_LW, ALU_LBU, ALU_LHU: ex_is_load = 1'b1;
			default:                                 ex_is_load = 1'b0;
		endcase
	end

	assign ex_hit  = ex_fwd_i.wreg && (ex_fwd_i.wd == addr_i);
	assign mem_hit = mem_fwd_i.wreg && (mem_fwd_i.wd == addr_i);

	assign load_hazard_o = read_i && ex_is_load && (ex_fwd_i.wd == addr_i);

	always_comb begin
		if (!read_i)
			op_o = imm_i;
		else if (load_hazard_o)
			op_o = rf_data_i; // don't care, the register takes a bubble
		else if (ex_hit)
			op_o = ex_fwd_i.wdata; // youngest write wins
		else if (mem_hit)
			op_o = mem_fwd_i.wdata;
		else
			op_o = rf_data_i;
	end

endmodule

/* riscv_id_pkg.sv */
package riscv_id_pkg;

	localparam int XLEN = 32;

	typedef logic [XLEN-1:0] xlen_t;
	typedef logic [31:0]     inst_t;
	typedef logic [4:0]      reg_addr_t;
	typedef logic [7:0]      aluop_t;
	typedef logic [2:0]      alusel_t;
	typedef logic [2:0]      br_kind_t;

	// major opcodes, inst[6:0]
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;

	// funct3, shared by the register and immediate forms
	localparam logic [2:0] FUNCT3_ADD  = 3'b000; // also sub
	localparam logic [2:0] FUNCT3_SLL  = 3'b001;
	localparam logic [2:0] FUNCT3_SLT  = 3'b010;
	localparam logic [2:0] FUNCT3_SLTU = 3'b011;
	localparam logic [2:0] FUNCT3_XOR  = 3'b100;
	localparam logic [2:0] FUNCT3_SRL  = 3'b101; // also sra
	localparam logic [2:0] FUNCT3_OR   = 3'b110;
	localparam logic [2:0] FUNCT3_AND  = 3'b111;
	localparam logic [2:0] FUNCT3_JALR = 3'b000;
	localparam logic [2:0] FUNCT3_BEQ  = 3'b000;
	localparam logic [2:0] FUNCT3_BNE  = 3'b001;
	localparam logic [2:0] FUNCT3_BLT  = 3'b100;
	localparam logic [2:0] FUNCT3_BGE  = 3'b101;
	localparam logic [2:0] FUNCT3_BLTU = 3'b110;
	localparam logic [2:0] FUNCT3_BGEU = 3'b111;
	localparam logic [2:0] FUNCT3_LB   = 3'b000;
	localparam logic [2:0] FUNCT3_LH   = 3'b001;
	localparam logic [2:0] FUNCT3_LW   = 3'b010;
	localparam logic [2:0] FUNCT3_LBU  = 3'b100;
	localparam logic [2:0] FUNCT3_LHU  = 3'b101;
	localparam logic [2:0] FUNCT3_SB   = 3'b000;
	localparam logic [2:0] FUNCT3_SH   = 3'b001;
	localparam logic [2:0] FUNCT3_SW   = 3'b010;

	localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
	localparam logic [6:0] FUNCT7_ALT  = 7'b0100000; // sub, sra

	// execute operation codes
	localparam aluop_t ALU_NOP    = 8'b0000_0000;
	localparam aluop_t ALU_ADD    = 8'b0010_0000;
	localparam aluop_t ALU_SUB    = 8'b0010_0010;
	localparam aluop_t ALU_SLT    = 8'b0010_1010;
	localparam aluop_t ALU_SLTU   = 8'b0010_1011;
	localparam aluop_t ALU_XOR    = 8'b0010_0110;
	localparam aluop_t ALU_OR     = 8'b0010_0101;
	localparam aluop_t ALU_AND    = 8'b0010_0100;
	localparam aluop_t ALU_SLL    = 8'b0111_1100;
	localparam aluop_t ALU_SRL    = 8'b0000_0010;
	localparam aluop_t ALU_SRA    = 8'b0000_0011;
	localparam aluop_t ALU_JAL    = 8'b0101_0000;
	localparam aluop_t ALU_JALR   = 8'b0000_1001;
	localparam aluop_t ALU_BRANCH = 8'b0101_0001;
	localparam aluop_t ALU_LB     = 8'b1110_0000;
	localparam aluop_t ALU_LH     = 8'b1110_0001;
	localparam aluop_t ALU_LW     = 8'b1110_0011;
	localparam aluop_t ALU_LBU    = 8'b1110_0100;
	localparam aluop_t ALU_LHU    = 8'b1110_0101;
	localparam aluop_t ALU_SB     = 8'b1110_1000;
	localparam aluop_t ALU_SH     = 8'b1110_1001;
	localparam aluop_t ALU_SW     = 8'b1110_1011;

	// result class seen by execute
	localparam alusel_t SEL_NOP         = 3'b000;
	localparam alusel_t SEL_LOGIC       = 3'b001;
	localparam alusel_t SEL_SHIFT       = 3'b010;
	localparam alusel_t SEL_ARITH       = 3'b100;
	localparam alusel_t SEL_JUMP_BRANCH = 3'b110;
	localparam alusel_t SEL_LOAD_STORE  = 3'b111;

	localparam br_kind_t BR_NONE = 3'd0;
	localparam br_kind_t BR_EQ   = 3'd1;
	localparam br_kind_t BR_NE   = 3'd2;
	localparam br_kind_t BR_LT   = 3'd3;
	localparam br_kind_t BR_GE   = 3'd4;
	localparam br_kind_t BR_LTU  = 3'd5;
	localparam br_kind_t BR_GEU  = 3'd6;
	localparam br_kind_t BR_JAL  = 3'd7;

	// jalr is told apart from jal by rs1_read, see branch_resolve
	localparam br_kind_t BR_JALR = 3'd7;

	typedef struct packed {
		aluop_t    aluop;
		alusel_t   alusel;
		logic      wreg;
		reg_addr_t wd;
		logic      rs1_read;
		logic      rs2_read;
		reg_addr_t rs1;
		reg_addr_t rs2;
		xlen_t     imm;
		xlen_t     link_addr;
		br_kind_t  br_kind;
	} dec_ctrl_t;

	// pending write of a later stage
	typedef struct packed {
		logic      wreg;
		reg_addr_t wd;
		xlen_t     wdata;
		aluop_t    aluop;
	} fwd_src_t;

	typedef struct packed {
		aluop_t    aluop;
		alusel_t   alusel;
		logic      wreg;
		reg_addr_t wd;
		xlen_t     op1;
		xlen_t     op2;
		xlen_t     link_addr;
	} id_ex_t;

	typedef struct packed {
		logic  flag;
		xlen_t target;
	} redirect_t;

	typedef struct packed {
		logic is_branch;
		logic taken;
		logic pred_true;
	} br_status_t;

	localparam dec_ctrl_t DEC_BUBBLE = '{
		aluop: ALU_NOP, alusel: SEL_NOP, br_kind: BR_NONE, default: '0
	};

	localparam id_ex_t ID_EX_BUBBLE = '{aluop: ALU_NOP, alusel: SEL_NOP, default: '0};

endpackage

/* src.f */
+incdir+.
riscv_id_pkg.sv
inst_decoder.sv
operand_forward.sv
branch_resolve.sv
id_ex_reg.sv
id_stage.sv
tb_id_stage.sv

/* tb_id_model.svh */
`ifndef TB_ID_MODEL_SVH
`define TB_ID_MODEL_SVH

// expected response of the decode stage for one presented instruction
typedef struct packed {
	reg_addr_t  rs1;
	reg_addr_t  rs2;
	logic       stall;
	redirect_t  redirect;
	br_status_t status;
	id_ex_t     id_ex;
} model_out_t;

function automatic id_ex_t bubble_bundle();
	id_ex_t b;
	b        = '0;
	b.aluop  = ALU_NOP;
	b.alusel = SEL_NOP;
	return b;
endfunction

function automatic logic is_load_op(input aluop_t op);
	return (op == ALU_LB) || (op == ALU_LH) || (op == ALU_LW) ||
		(op == ALU_LBU) || (op == ALU_LHU);
endfunction

// execute first, then memory, then the register file
function automatic xlen_t expected_operand(input logic used, input reg_addr_t src,
		input xlen_t rf, input xlen_t imm, input fwd_src_t ex, input fwd_src_t mem,
		output logic hazard);
	hazard = used && is_load_op(ex.aluop) && ex.wreg && (ex.wd == src);
	if (!used)
		return imm;
	if (hazard)
		return 32'd0; // value is dropped, a bubble follows
	if (ex.wreg && ex.wd == src)
		return ex.wdata;
	if (mem.wreg && mem.wd == src)
		return mem.wdata;
	return rf;
endfunction

function automatic model_out_t expected_outputs(input inst_t inst, input xlen_t pc,
		input logic pred, input fwd_src_t ex, input fwd_src_t mem,
		input xlen_t rf1, input xlen_t rf2);
	model_out_t m;
	logic [2:0] f3;
	logic [6:0] f7;
	logic       ok;
	logic       wr;
	logic       use1;
	logic       use2;
	logic       reg_form;
	logic       shift;
	logic       hz1;
	logic       hz2;
	logic       cmp;
	logic       is_cond;
	logic       is_jal;
	logic       is_jalr;
	aluop_t     op;
	alusel_t    sel;
	xlen_t      imm_i;
	xlen_t      imm;
	xlen_t      link;
	xlen_t      a;
	xlen_t      b;

	f3      = inst[14:12];
	f7      = inst[31:25];
	imm_i   = {{20{inst[31]}}, inst[31:20]};
	ok      = 1'b1;
	wr      = 1'b0;
	use1    = 1'b0;
	use2    = 1'b0;
	is_cond = 1'b0;
	is_jal  = 1'b0;
	is_jalr = 1'b0;
	op      = ALU_NOP;
	sel     = SEL_NOP;
	imm     = 32'd0;
	link    = 32'd0;

	case (inst[6:0])
		OPC_OP_IMM, OPC_OP: begin
			reg_form = (inst[6:0] == OPC_OP);
			shift    = (f3 == FUNCT3_SLL) || (f3 == FUNCT3_SRL);
			wr       = 1'b1;
			use1     = 1'b1;
			use2     = reg_form;
			if (!reg_form)
				imm = shift ? {27'b0, inst[24:20]} : imm_i;
			case (f3)
				FUNCT3_ADD:  op = (reg_form && f7 == FUNCT7_ALT) ? ALU_SUB : ALU_ADD;
				FUNCT3_SLL:  op = ALU_SLL;
				FUNCT3_SLT:  op = ALU_SLT;
				FUNCT3_SLTU: op = ALU_SLTU;
				FUNCT3_XOR:  op = ALU_XOR;
				FUNCT3_OR:   op = ALU_OR;
				FUNCT3_AND:  op = ALU_AND;
				default:     op = (f7 == FUNCT7_ALT) ? ALU_SRA : ALU_SRL;
			endcase
			// immediate forms carry imm bits in funct7 except for shifts
			if (reg_form || shift)
				ok = (f7 == FUNCT7_BASE) ||
					(f7 == FUNCT7_ALT && (f3 == FUNCT3_ADD || f3 == FUNCT3_SRL));
			if (op == ALU_SLL || op == ALU_SRL || op == ALU_SRA)
				sel = SEL_SHIFT;
			else if (op == ALU_XOR || op == ALU_OR || op == ALU_AND)
				sel = SEL_LOGIC;
			else
				sel = SEL_ARITH;
		end
		OPC_LUI: begin
			op   = ALU_SLL;
			sel  = SEL_JUMP_BRANCH;
			wr   = 1'b1;
			link = {inst[31:12], 12'b0};
		end
		OPC_AUIPC: begin
			op   = ALU_ADD;
			sel  = SEL_JUMP_BRANCH;
			wr   = 1'b1;
			link = pc + {inst[31:12], 12'b0};
		end
		OPC_JAL: begin
			op     = ALU_JAL;
			sel    = SEL_JUMP_BRANCH;
			wr     = 1'b1;
			link   = pc + 32'd4;
			is_jal = 1'b1;
		end
		OPC_JALR: begin
			op      = ALU_JALR;
			sel     = SEL_JUMP_BRANCH;
			wr      = 1'b1;
			use1    = 1'b1;
			imm     = imm_i;
			link    = pc + 32'd4;
			is_jalr = 1'b1;
			ok      = (f3 == FUNCT3_JALR);
		end
		OPC_BRANCH: begin
			op      = ALU_BRANCH;
			sel     = SEL_JUMP_BRANCH;
			use1    = 1'b1;
			use2    = 1'b1;
			is_cond = 1'b1;
			ok      = (f3 != 3'b010) && (f3 != 3'b011);
		end
		OPC_LOAD: begin
			sel  = SEL_LOAD_STORE;
			wr   = 1'b1;
			use1 = 1'b1;
			imm  = imm_i;
			case (f3)
				FUNCT3_LB:  op = ALU_LB;
				FUNCT3_LH:  op = ALU_LH;
				FUNCT3_LW:  op = ALU_LW;
				FUNCT3_LBU: op = ALU_LBU;
				FUNCT3_LHU: op = ALU_LHU;
				default:    ok = 1'b0;
			endcase
		end
		OPC_STORE: begin
			sel  = SEL_LOAD_STORE;
			use1 = 1'b1;
			use2 = 1'b1;
			case (f3)
				FUNCT3_SB: op = ALU_SB;
				FUNCT3_SH: op = ALU_SH;
				FUNCT3_SW: op = ALU_SW;
				default:   ok = 1'b0;
			endcase
		end
		default: ok = 1'b0;
	endcase

	if (!ok) begin
		op      = ALU_NOP;
		sel     = SEL_NOP;
		wr      = 1'b0;
		use1    = 1'b0;
		use2    = 1'b0;
		imm     = 32'd0;
		link    = 32'd0;
		is_cond = 1'b0;
		is_jal  = 1'b0;
		is_jalr = 1'b0;
	end

	a = expected_operand(use1, inst[19:15], rf1, imm, ex, mem, hz1);
	b = expected_operand(use2, inst[24:20], rf2, imm, ex, mem, hz2);

	m.rs1   = inst[19:15];
	m.rs2   = inst[24:20];
	m.stall = hz1 | hz2;
	m.id_ex = bubble_bundle();
	if (!m.stall) begin
		m.id_ex.aluop     = op;
		m.id_ex.alusel    = sel;
		m.id_ex.wreg      = wr;
		m.id_ex.wd        = wr ? inst[11:7] : 5'd0;
		m.id_ex.op1       = a;
		m.id_ex.op2       = b;
		m.id_ex.link_addr = link;
	end

	m.status   = '0;
	m.redirect = '0;
	if (is_cond) begin
		case (f3)
			FUNCT3_BEQ:  cmp = (a == b);
			FUNCT3_BNE:  cmp = (a != b);
			FUNCT3_BLT:  cmp = ($signed(a) < $signed(b));
			FUNCT3_BGE:  cmp = ($signed(a) >= $signed(b));
			FUNCT3_BLTU: cmp = (a < b);
			default:     cmp = (a >= b);
		endcase
		m.status.is_branch = 1'b1;
		m.status.taken     = cmp;
		m.status.pred_true = cmp && pred;
		m.redirect.flag    = cmp && !pred; // fetch already went the other way
		m.redirect.target  = pc + {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
	end else if (is_jal) begin
		m.redirect.flag   = 1'b1;
		m.redirect.target = pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
	end else if (is_jalr) begin
		m.redirect.flag   = 1'b1;
		m.redirect.target = a + imm_i;
	end
	return m;
endfunction

`endif

/* tb_id_stage.sv */
`timescale 1ns/1ps

module tb_id_stage import riscv_id_pkg::*; ();

	localparam int CLK_PERIOD     = 4;
	localparam int RESET_CYCLES   = 5;
	localparam int N_CYCLES       = 2000;
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + N_CYCLES + 95;

	logic       clk;
	logic       arst_n_i;
	inst_t      inst;
	xlen_t      pc;
	logic       pred_taken;
	fwd_src_t   ex_fwd;
	fwd_src_t   mem_fwd;
	xlen_t      rs1_data;
	xlen_t      rs2_data;
	reg_addr_t  rs1_addr;
	reg_addr_t  rs2_addr;
	id_ex_t     id_ex;
	redirect_t  redirect;
	br_status_t br_status;
	logic       stall;

	logic [31:0] lfsr_state;
	int          errors = 0;
	int          cycles = 0;

	`include "tb_id_model.svh"

	id_stage dut (
		.clk          (clk),
		.arst_n_i     (arst_n_i),
		.inst_i       (inst),
		.pc_i         (pc),
		.pred_taken_i (pred_taken),
		.ex_fwd_i     (ex_fwd),
		.mem_fwd_i    (mem_fwd),
		.rs1_data_i   (rs1_data),
		.rs2_data_i   (rs2_data),
		.rs1_addr_o   (rs1_addr),
		.rs2_addr_o   (rs2_addr),
		.id_ex_o      (id_ex),
		.redirect_o   (redirect),
		.br_status_o  (br_status),
		.stall_o      (stall)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
			abort_run();
		end
	end

	task automatic abort_run();
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	// galois lfsr, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_state[0]};
			if (lfsr_state[0])
				lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
			else
				lfsr_state = lfsr_state >> 1;
		end
		return v;
	endfunction

	function automatic logic [6:0] kept_opcode(input int idx);
		case (idx)
			0:       return OPC_OP_IMM;
			1:       return OPC_OP;
			2:       return OPC_LUI;
			3:       return OPC_AUIPC;
			4:       return OPC_JAL;
			5:       return OPC_JALR;
			6:       return OPC_BRANCH;
			7:       return OPC_LOAD;
			default: return OPC_STORE;
		endcase
	endfunction

	// destination leans toward the sources of the current instruction
	function automatic fwd_src_t random_fwd(input reg_addr_t src1, input reg_addr_t src2);
		fwd_src_t    f;
		logic [31:0] r;
		r = rand_bits(2);
		if (r[1:0] == 2'd0) begin
			f.wd = src1;
		end else if (r[1:0] == 2'd1) begin
			f.wd = src2;
		end else begin
			r    = rand_bits(5);
			f.wd = r[4:0];
		end
		r       = rand_bits(1);
		f.wreg  = r[0];
		f.wdata = rand_bits(32);
		r       = rand_bits(3);
		if (r[2:0] == 3'd0) begin
			r = rand_bits(3);
			case (r[2:0])
				3'd0:    f.aluop = ALU_LB;
				3'd1:    f.aluop = ALU_LH;
				3'd2:    f.aluop = ALU_LW;
				3'd3:    f.aluop = ALU_LBU;
				default: f.aluop = ALU_LHU;
			endcase
		end else begin
			r       = rand_bits(8);
			f.aluop = r[7:0];
		end
		if (is_load_op(f.aluop))
			f.wreg = 1'b1; // a load always writes back
		return f;
	endfunction

	task automatic drive_random();
		logic [31:0] r;
		logic [6:0]  opc;
		inst_t       w;
		r = rand_bits(5);
		if (r[4:0] >= 5'd27) begin
			r   = rand_bits(7);
			opc = r[6:0]; // mostly invalid
		end else begin
			opc = kept_opcode(r[4:0] % 9);
		end
		r = rand_bits(25);
		w = {r[24:0], opc};
		if (opc == OPC_OP || opc == OPC_OP_IMM) begin
			r = rand_bits(2);
			if (r[1:0] < 2'd2)
				w[31:25] = FUNCT7_BASE;
			else if (r[1:0] == 2'd2)
				w[31:25] = FUNCT7_ALT;
		end
		inst       = w;
		r          = rand_bits(30);
		pc         = {r[29:0], 2'b00};
		r          = rand_bits(1);
		pred_taken = r[0];
		rs1_data   = rand_bits(32);
		r          = rand_bits(2);
		rs2_data   = (r[1:0] == 2'd0) ? rs1_data : rand_bits(32); // equal operands now and then
		ex_fwd     = random_fwd(w[19:15], w[24:20]);
		mem_fwd    = random_fwd(w[19:15], w[24:20]);
	endtask

	task automatic check_id_ex(input id_ex_t got, input id_ex_t exp);
		if (got !== exp) begin
			errors++;
			$display("error id_ex_o: got %h expected %h", got, exp);
			abort_run();
		end
	endtask

	task automatic check_redirect(input redirect_t got, input redirect_t exp);
		if (got.flag !== exp.flag || (exp.flag && got.target !== exp.target)) begin
			errors++;
			$display("error redirect_o: got %h expected %h", got, exp);
			abort_run();
		end
	endtask

	task automatic check_status(input br_status_t got, input br_status_t exp);
		if (got !== exp) begin
			errors++;
			$display("error br_status_o: got %h expected %h", got, exp);
			abort_run();
		end
	endtask

	task automatic check_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
		if (got !== exp) begin
			errors++;
			$display("error %s: got %h expected %h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_stall(input logic got, input logic exp);
		if (got !== exp) begin
			errors++;
			$display("error stall_o: got %h expected %h", got, exp);
			abort_run();
		end
	endtask

	task automatic check_decode(output id_ex_t next_id_ex);
		model_out_t m;
		m = expected_outputs(inst, pc, pred_taken, ex_fwd, mem_fwd, rs1_data, rs2_data);
		check_addr("rs1_addr_o", rs1_addr, m.rs1);
		check_addr("rs2_addr_o", rs2_addr, m.rs2);
		check_stall(stall, m.stall);
		// a stalled lane has no valid operand to compare with
		if (!m.stall) begin
			check_redirect(redirect, m.redirect);
			check_status(br_status, m.status);
		end
		next_id_ex = m.id_ex;
	endtask

	initial begin
		id_ex_t pending;
		arst_n_i   = 1'b0;
		inst       = '0;
		pc         = '0;
		pred_taken = 1'b0;
		ex_fwd     = '0;
		mem_fwd    = '0;
		rs1_data   = '0;
		rs2_data   = '0;
		lfsr_state = 32'd6711;
		pending    = bubble_bundle();

		for (int n = 0; n < RESET_CYCLES + N_CYCLES; n++) begin
			@(negedge clk);
			check_id_ex(id_ex, pending);
			if (n == RESET_CYCLES)
				arst_n_i = 1'b1;
			drive_random();
			#1;
			check_decode(pending);
			if (!arst_n_i)
				pending = bubble_bundle(); // next edge is still in reset
		end
		@(negedge clk);
		check_id_ex(id_ex, pending);

		if (errors == 0) begin
			$display("TESTBENCH PASSED");
			$finish;
		end else begin
			abort_run();
		end
	end

endmodule
